//--- rtl/cache_defines.svh
// Cache geometry constants
// 2-way set-associative, 4-word lines, 16 sets, 16-bit byte addresses

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

`define CACHE_ADDR_WIDTH 16
`define CACHE_DATA_WIDTH 32
`define CACHE_MASK_WIDTH 4
`define CACHE_BLOCK_WORDS 4
`define CACHE_SETS 16
`define CACHE_WAYS 2

// derived address fields
`define CACHE_OFFSET_WIDTH ($clog2(`CACHE_BLOCK_WORDS) + $clog2(`CACHE_MASK_WIDTH))
`define CACHE_INDEX_WIDTH ($clog2(`CACHE_SETS))
`define CACHE_TAG_WIDTH (`CACHE_ADDR_WIDTH - `CACHE_INDEX_WIDTH - `CACHE_OFFSET_WIDTH)
`define CACHE_WORD_SEL_WIDTH ($clog2(`CACHE_BLOCK_WORDS))

`endif

//--- rtl/cache_pkg.sv
// Cache types
// request, tag row, data row and miss-unit state encodings

`include "cache_defines.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;
  typedef logic [`CACHE_MASK_WIDTH-1:0] mask_t;
  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

  // one entry per way in the tag array
  typedef struct packed {
    logic                        valid;
    logic [`CACHE_TAG_WIDTH-1:0] tag;
  } tag_info_t;

  typedef tag_info_t [`CACHE_WAYS-1:0] tag_row_t;
  typedef word_t [`CACHE_WAYS-1:0] data_row_t;

  // held in the TL and TV stage registers
  typedef struct packed {
    logic  store;
    addr_t addr;
    word_t data;
    mask_t mask;
  } cache_req_t;

  typedef enum logic [2:0] {
    MISS_IDLE,
    MISS_EVICT_REQ,
    MISS_EVICT_DATA,
    MISS_FILL_REQ,
    MISS_FILL_DATA,
    MISS_INSTALL,
    MISS_DONE
  } miss_state_e;

endpackage

//--- rtl/sram_if.sv
// Single-port array bus
// one request per cycle, rdata returns the row of the last read

`timescale 1ns/1ps
`include "cache_defines.svh"

interface sram_if #(
  parameter type payload_t = cache_pkg::data_row_t,
  parameter int addr_width_p = `CACHE_INDEX_WIDTH
) ();

  logic                    v;
  logic                    w;
  logic [addr_width_p-1:0] addr;
  payload_t                wdata;
  logic [`CACHE_WAYS-1:0]  way_we;
  payload_t                rdata;

  modport master (output v, w, addr, wdata, way_we, input rdata);
  modport slave (input v, w, addr, wdata, way_we, output rdata);

endinterface

//--- rtl/miss_if.sv
// Pipeline to miss unit link
// miss description one way, array requests and fill result the other

`timescale 1ns/1ps
`include "cache_defines.svh"

interface miss_if ();

  logic                                           start;
  cache_pkg::addr_t                               addr;
  logic [`CACHE_WAYS-1:0]                         valid;
  logic [`CACHE_WAYS-1:0][`CACHE_TAG_WIDTH-1:0]   tags;
  logic                                           busy;
  logic                                           done;
  cache_pkg::way_t                                way;
  cache_pkg::word_t                               fill_word;
  logic                                           mem_v;
  logic                                           mem_w;
  logic                                           mem_tag_w;
  logic [`CACHE_INDEX_WIDTH+`CACHE_WORD_SEL_WIDTH-1:0] mem_addr;
  cache_pkg::word_t                               mem_wdata;
  cache_pkg::data_row_t                           mem_rdata;

  modport pipe (
    output start, addr, valid, tags, mem_rdata,
    input  busy, done, way, fill_word, mem_v, mem_w, mem_tag_w, mem_addr, mem_wdata
  );
  modport miss (
    input  start, addr, valid, tags, mem_rdata,
    output busy, done, way, fill_word, mem_v, mem_w, mem_tag_w, mem_addr, mem_wdata
  );

endinterface

//--- rtl/cache_sram.sv
// Synchronous single-port array
// per-way write enables, registered read with one cycle latency

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_sram #(
  parameter type payload_t = cache_pkg::data_row_t,
  parameter int addr_width_p = `CACHE_INDEX_WIDTH
) (
  input logic   clk_i,
  input logic   reset_i,
  sram_if.slave bus
);

  localparam int rows_lp = 2 ** addr_width_p;

  payload_t mem [rows_lp];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // tag valid bits must come up clear
      for (int r = 0; r < rows_lp; r++) begin
        mem[r] <= '0;
      end
      bus.rdata <= '0;
    end else if (bus.v) begin
      if (bus.w) begin
        for (int i = 0; i < `CACHE_WAYS; i++) begin
          if (bus.way_we[i]) begin
            mem[bus.addr][i] <= bus.wdata[i];
          end
        end
      end else begin
        bus.rdata <= mem[bus.addr];
      end
    end
  end

endmodule

//--- rtl/cache_stat_regs.sv
// Per-set replacement and dirty state
// one LRU bit and one dirty bit per way, read combinationally

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_stat_regs (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          hit_v_i,
  input  logic [`CACHE_INDEX_WIDTH-1:0] hit_set_i,
  input  cache_pkg::way_t               hit_way_i,
  input  logic                          hit_store_i,
  input  logic                          fill_v_i,
  input  logic [`CACHE_INDEX_WIDTH-1:0] fill_set_i,
  input  cache_pkg::way_t               fill_way_i,
  input  logic [`CACHE_INDEX_WIDTH-1:0] read_set_i,
  output logic [`CACHE_WAYS-1:0]        dirty_o,
  output cache_pkg::way_t               lru_o
);

  logic [`CACHE_WAYS-1:0] dirty_r [`CACHE_SETS];
  cache_pkg::way_t        lru_r [`CACHE_SETS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        dirty_r[s] <= '0;
        lru_r[s]   <= '0;
      end
    end else begin
      // lru bit names the way to evict next
      if (hit_v_i) begin
        lru_r[hit_set_i] <= ~hit_way_i;
        if (hit_store_i) begin
          dirty_r[hit_set_i][hit_way_i] <= 1'b1;
        end
      end
      if (fill_v_i) begin
        lru_r[fill_set_i]               <= ~fill_way_i;
        dirty_r[fill_set_i][fill_way_i] <= 1'b0;
      end
    end
  end

  assign dirty_o = dirty_r[read_set_i];
  assign lru_o   = lru_r[read_set_i];

endmodule

//--- rtl/cache_miss.sv
// Miss handler
// picks a victim, writes back a dirty line, refills the line word by word
// over DMA, captures the requested word and installs the new tag

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_miss (
  input  logic                          clk_i,
  input  logic                          reset_i,
  miss_if.miss                          miss,
  output logic [`CACHE_INDEX_WIDTH-1:0] read_set_o,
  input  logic [`CACHE_WAYS-1:0]        dirty_i,
  input  cache_pkg::way_t               lru_i,
  output logic                          fill_v_o,
  output logic [`CACHE_INDEX_WIDTH-1:0] fill_set_o,
  output cache_pkg::way_t               fill_way_o,
  output logic                          dma_pkt_v_o,
  output logic                          dma_pkt_write_o,
  output cache_pkg::addr_t              dma_pkt_addr_o,
  input  logic                          dma_pkt_yumi_i,
  input  cache_pkg::word_t              dma_data_i,
  input  logic                          dma_data_v_i,
  output logic                          dma_data_ready_o,
  output cache_pkg::word_t              dma_data_o,
  output logic                          dma_data_v_o,
  input  logic                          dma_data_yumi_i
);

  localparam int byte_w_lp  = `CACHE_OFFSET_WIDTH - `CACHE_WORD_SEL_WIDTH;
  localparam int tag_lsb_lp = `CACHE_OFFSET_WIDTH + `CACHE_INDEX_WIDTH;

  cache_pkg::miss_state_e                state_r;
  cache_pkg::way_t                       way_r;
  cache_pkg::way_t                       victim;
  logic [`CACHE_WORD_SEL_WIDTH-1:0]      cnt_r;
  logic                                  word_v_r;
  cache_pkg::word_t                      fill_word_r;
  logic [`CACHE_INDEX_WIDTH-1:0]         set;
  logic [`CACHE_TAG_WIDTH-1:0]           tag;
  logic [`CACHE_WORD_SEL_WIDTH-1:0]      req_word;
  logic                                  last_word;

  assign set       = miss.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign tag       = miss.addr[tag_lsb_lp +: `CACHE_TAG_WIDTH];
  assign req_word  = miss.addr[byte_w_lp +: `CACHE_WORD_SEL_WIDTH];
  assign last_word = &cnt_r;

  // lowest invalid way wins, otherwise the lru way
  always_comb begin
    victim = lru_i;
    for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
      if (!miss.valid[i]) begin
        victim = cache_pkg::way_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= cache_pkg::MISS_IDLE;
      cnt_r    <= '0;
      word_v_r <= 1'b0;
    end else begin
      case (state_r)
        cache_pkg::MISS_IDLE: begin
          if (miss.start) begin
            cnt_r   <= '0;
            state_r <= (miss.valid[victim] & dirty_i[victim])
                       ? cache_pkg::MISS_EVICT_REQ : cache_pkg::MISS_FILL_REQ;
          end
        end
        cache_pkg::MISS_EVICT_REQ: begin
          if (dma_pkt_yumi_i) begin
            state_r <= cache_pkg::MISS_EVICT_DATA;
          end
        end
        cache_pkg::MISS_EVICT_DATA: begin
          // read a word, then offer it until taken
          if (!word_v_r) begin
            word_v_r <= 1'b1;
          end else if (dma_data_yumi_i) begin
            word_v_r <= 1'b0;
            cnt_r    <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= cache_pkg::MISS_FILL_REQ;
            end
          end
        end
        cache_pkg::MISS_FILL_REQ: begin
          if (dma_pkt_yumi_i) begin
            state_r <= cache_pkg::MISS_FILL_DATA;
          end
        end
        cache_pkg::MISS_FILL_DATA: begin
          if (dma_data_v_i) begin
            cnt_r <= cnt_r + 1'b1;
            if (last_word) begin
              state_r <= cache_pkg::MISS_INSTALL;
            end
          end
        end
        cache_pkg::MISS_INSTALL: state_r <= cache_pkg::MISS_DONE;
        default: state_r <= cache_pkg::MISS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == cache_pkg::MISS_IDLE && miss.start) begin
      way_r <= victim;
    end
    if (state_r == cache_pkg::MISS_FILL_DATA && dma_data_v_i && cnt_r == req_word) begin
      fill_word_r <= dma_data_i;
    end
  end

  assign miss.busy      = (state_r != cache_pkg::MISS_IDLE);
  assign miss.done      = (state_r == cache_pkg::MISS_DONE);
  assign miss.way       = way_r;
  assign miss.fill_word = fill_word_r;

  // array requests, routed by the pipe while busy
  assign miss.mem_v     = ((state_r == cache_pkg::MISS_EVICT_DATA) & ~word_v_r)
                        | ((state_r == cache_pkg::MISS_FILL_DATA) & dma_data_v_i)
                        | (state_r == cache_pkg::MISS_INSTALL);
  assign miss.mem_w     = (state_r != cache_pkg::MISS_EVICT_DATA);
  assign miss.mem_tag_w = (state_r == cache_pkg::MISS_INSTALL);
  assign miss.mem_addr  = {set, cnt_r};
  assign miss.mem_wdata = dma_data_i;

  assign dma_pkt_v_o     = (state_r == cache_pkg::MISS_EVICT_REQ)
                         | (state_r == cache_pkg::MISS_FILL_REQ);
  assign dma_pkt_write_o = (state_r == cache_pkg::MISS_EVICT_REQ);
  assign dma_pkt_addr_o  = {dma_pkt_write_o ? miss.tags[way_r] : tag, set,
                            {`CACHE_OFFSET_WIDTH{1'b0}}};

  assign dma_data_o       = miss.mem_rdata[way_r];
  assign dma_data_v_o     = (state_r == cache_pkg::MISS_EVICT_DATA) & word_v_r;
  assign dma_data_ready_o = (state_r == cache_pkg::MISS_FILL_DATA);

  assign read_set_o = set;
  assign fill_v_o   = (state_r == cache_pkg::MISS_INSTALL);
  assign fill_set_o = set;
  assign fill_way_o = way_r;

endmodule

//--- rtl/cache_pipe.sv
// Cache pipeline
// tag lookup (TL) reads the arrays, tag verify (TV) checks the hit,
// answers loads, merges and writes stores, and hands misses to the miss unit

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_pipe (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          v_i,
  input  logic                          store_i,
  input  cache_pkg::addr_t              addr_i,
  input  cache_pkg::word_t              data_i,
  input  cache_pkg::mask_t              mask_i,
  output logic                          yumi_o,
  output cache_pkg::word_t              data_o,
  output logic                          v_o,
  input  logic                          yumi_i,
  sram_if.master                        tag_bus,
  sram_if.master                        data_bus,
  miss_if.pipe                          miss,
  output logic                          hit_v_o,
  output logic [`CACHE_INDEX_WIDTH-1:0] hit_set_o,
  output cache_pkg::way_t               hit_way_o,
  output logic                          hit_store_o
);

  localparam int byte_w_lp  = `CACHE_OFFSET_WIDTH - `CACHE_WORD_SEL_WIDTH;
  localparam int daddr_w_lp = `CACHE_INDEX_WIDTH + `CACHE_WORD_SEL_WIDTH;
  localparam int tag_lsb_lp = `CACHE_OFFSET_WIDTH + `CACHE_INDEX_WIDTH;

  cache_pkg::cache_req_t         req_in;
  cache_pkg::cache_req_t         tl_r;
  cache_pkg::cache_req_t         tv_r;
  logic                          tl_v_r;
  logic                          tv_v_r;
  logic                          tv_fill_r;
  cache_pkg::tag_row_t           tv_tags_r;
  cache_pkg::data_row_t          tv_data_r;
  logic                          tl_we;
  logic                          tv_we;
  logic [`CACHE_WAYS-1:0]        tv_hit_ways;
  logic                          tv_hit;
  cache_pkg::way_t               hit_way;
  cache_pkg::way_t               sel_way;
  cache_pkg::word_t              base_word;
  cache_pkg::word_t              st_word;
  logic                          st_wr;
  logic                          fwd;
  cache_pkg::tag_info_t          new_tag;
  logic [`CACHE_WAYS-1:0]        miss_way_oh;
  logic [`CACHE_WAYS-1:0]        st_way_oh;
  logic [`CACHE_INDEX_WIDTH-1:0] in_set;
  logic [`CACHE_INDEX_WIDTH-1:0] tl_set;
  logic [`CACHE_INDEX_WIDTH-1:0] tv_set;
  logic [daddr_w_lp-1:0]         in_daddr;
  logic [daddr_w_lp-1:0]         tl_daddr;
  logic [daddr_w_lp-1:0]         tv_daddr;

  assign req_in   = '{store: store_i, addr: addr_i, data: data_i, mask: mask_i};
  assign in_set   = addr_i[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign tl_set   = tl_r.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign tv_set   = tv_r.addr[`CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
  assign in_daddr = addr_i[byte_w_lp +: daddr_w_lp];
  assign tl_daddr = tl_r.addr[byte_w_lp +: daddr_w_lp];
  assign tv_daddr = tv_r.addr[byte_w_lp +: daddr_w_lp];

  // hit check in TV
  always_comb begin
    hit_way = '0;
    for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
      tv_hit_ways[i] = tv_tags_r[i].valid
                     & (tv_tags_r[i].tag == tv_r.addr[tag_lsb_lp +: `CACHE_TAG_WIDTH]);
      if (tv_hit_ways[i]) begin
        hit_way = cache_pkg::way_t'(i);
      end
    end
  end
  assign tv_hit = |tv_hit_ways;

  // after a refill the word comes from the miss unit
  assign sel_way   = tv_fill_r ? miss.way : hit_way;
  assign base_word = tv_fill_r ? miss.fill_word : tv_data_r[hit_way];

  always_comb begin
    st_word = base_word;
    for (int b = 0; b < `CACHE_MASK_WIDTH; b++) begin
      if (tv_r.mask[b]) begin
        st_word[8*b +: 8] = tv_r.data[8*b +: 8];
      end
    end
  end

  assign v_o    = tv_v_r & (tv_hit | tv_fill_r);
  assign data_o = tv_r.store ? '0 : base_word;
  assign tv_we  = ~tv_v_r | (v_o & yumi_i);
  assign tl_we  = ~tl_v_r | tv_we;
  // a store in TV owns the data array on its way out
  assign yumi_o = v_i & tl_we & ~miss.busy & ~(tv_v_r & tv_r.store);
  assign st_wr  = v_o & yumi_i & tv_r.store;
  // the TL item read its word before this store lands
  assign fwd    = st_wr & tl_v_r & (tl_daddr == tv_daddr);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_r    <= 1'b0;
      tv_v_r    <= 1'b0;
      tv_fill_r <= 1'b0;
    end else begin
      if (tl_we) begin
        tl_v_r <= yumi_o;
      end
      if (tv_we) begin
        tv_v_r    <= tl_v_r;
        tv_fill_r <= 1'b0;
      end else if (miss.done) begin
        tv_fill_r <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi_o) begin
      tl_r <= req_in;
    end
    if (tv_we && tl_v_r) begin
      tv_r      <= tl_r;
      tv_tags_r <= tag_bus.rdata;
      tv_data_r <= data_bus.rdata;
      if (fwd) begin
        tv_data_r[sel_way] <= st_word;
      end
    end
  end

  assign new_tag     = '{valid: 1'b1, tag: tv_r.addr[tag_lsb_lp +: `CACHE_TAG_WIDTH]};
  assign miss_way_oh = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << miss.way;
  assign st_way_oh   = {{(`CACHE_WAYS-1){1'b0}}, 1'b1} << sel_way;

  // array arbitration: replay on done, then miss unit, then store, then new read
  always_comb begin
    tag_bus.v      = yumi_o;
    tag_bus.w      = 1'b0;
    tag_bus.addr   = in_set;
    tag_bus.wdata  = {`CACHE_WAYS{new_tag}};
    tag_bus.way_we = miss_way_oh;
    data_bus.v      = yumi_o;
    data_bus.w      = 1'b0;
    data_bus.addr   = in_daddr;
    data_bus.wdata  = {`CACHE_WAYS{st_word}};
    data_bus.way_we = st_way_oh;
    if (miss.done) begin
      tag_bus.v     = tl_v_r;
      tag_bus.addr  = tl_set;
      data_bus.v    = tl_v_r;
      data_bus.addr = tl_daddr;
    end else if (miss.busy) begin
      tag_bus.v       = miss.mem_v & miss.mem_tag_w;
      tag_bus.w       = miss.mem_w;
      tag_bus.addr    = tv_set;
      data_bus.v      = miss.mem_v & ~miss.mem_tag_w;
      data_bus.w      = miss.mem_w;
      data_bus.addr   = miss.mem_addr;
      data_bus.wdata  = {`CACHE_WAYS{miss.mem_wdata}};
      data_bus.way_we = miss_way_oh;
    end else if (st_wr) begin
      data_bus.v    = 1'b1;
      data_bus.w    = 1'b1;
      data_bus.addr = tv_daddr;
    end
  end

  // miss description from TV
  assign miss.start = tv_v_r & ~tv_hit & ~tv_fill_r;
  assign miss.addr  = tv_r.addr;
  always_comb begin
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      miss.valid[i] = tv_tags_r[i].valid;
      miss.tags[i]  = tv_tags_r[i].tag;
    end
  end
  assign miss.mem_rdata = data_bus.rdata;

  assign hit_v_o     = v_o & yumi_i;
  assign hit_set_o   = tv_set;
  assign hit_way_o   = sel_way;
  assign hit_store_o = tv_r.store;

endmodule

//--- rtl/cache.sv
// Data cache top level
// 2-way write-back, write-allocate cache with a DMA port for refills
// and write-backs

`timescale 1ns/1ps
`include "cache_defines.svh"

module cache (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             v_i,
  input  logic             store_i,
  input  cache_pkg::addr_t addr_i,
  input  cache_pkg::word_t data_i,
  input  cache_pkg::mask_t mask_i,
  output logic             yumi_o,
  output cache_pkg::word_t data_o,
  output logic             v_o,
  input  logic             yumi_i,
  output logic             dma_pkt_v_o,
  output logic             dma_pkt_write_o,
  output cache_pkg::addr_t dma_pkt_addr_o,
  input  logic             dma_pkt_yumi_i,
  input  cache_pkg::word_t dma_data_i,
  input  logic             dma_data_v_i,
  output logic             dma_data_ready_o,
  output cache_pkg::word_t dma_data_o,
  output logic             dma_data_v_o,
  input  logic             dma_data_yumi_i
);

  logic                          hit_v;
  logic [`CACHE_INDEX_WIDTH-1:0] hit_set;
  cache_pkg::way_t               hit_way;
  logic                          hit_store;
  logic                          fill_v;
  logic [`CACHE_INDEX_WIDTH-1:0] fill_set;
  cache_pkg::way_t               fill_way;
  logic [`CACHE_INDEX_WIDTH-1:0] read_set;
  logic [`CACHE_WAYS-1:0]        dirty;
  cache_pkg::way_t               lru;

  sram_if #(
    .payload_t    (cache_pkg::tag_row_t),
    .addr_width_p (`CACHE_INDEX_WIDTH)
  ) tag_bus ();

  sram_if #(
    .payload_t    (cache_pkg::data_row_t),
    .addr_width_p (`CACHE_INDEX_WIDTH + `CACHE_WORD_SEL_WIDTH)
  ) data_bus ();

  miss_if miss_bus ();

  cache_pipe pipe_i (
    .clk_i, .reset_i,
    .v_i, .store_i, .addr_i, .data_i, .mask_i, .yumi_o,
    .data_o, .v_o, .yumi_i,
    .tag_bus     (tag_bus.master),
    .data_bus    (data_bus.master),
    .miss        (miss_bus.pipe),
    .hit_v_o     (hit_v),
    .hit_set_o   (hit_set),
    .hit_way_o   (hit_way),
    .hit_store_o (hit_store)
  );

  cache_sram #(
    .payload_t    (cache_pkg::tag_row_t),
    .addr_width_p (`CACHE_INDEX_WIDTH)
  ) tag_mem_i (
    .clk_i, .reset_i,
    .bus (tag_bus.slave)
  );

  cache_sram #(
    .payload_t    (cache_pkg::data_row_t),
    .addr_width_p (`CACHE_INDEX_WIDTH + `CACHE_WORD_SEL_WIDTH)
  ) data_mem_i (
    .clk_i, .reset_i,
    .bus (data_bus.slave)
  );

  cache_stat_regs stat_i (
    .clk_i, .reset_i,
    .hit_v_i     (hit_v),
    .hit_set_i   (hit_set),
    .hit_way_i   (hit_way),
    .hit_store_i (hit_store),
    .fill_v_i    (fill_v),
    .fill_set_i  (fill_set),
    .fill_way_i  (fill_way),
    .read_set_i  (read_set),
    .dirty_o     (dirty),
    .lru_o       (lru)
  );

  cache_miss miss_i (
    .clk_i, .reset_i,
    .miss       (miss_bus.miss),
    .read_set_o (read_set),
    .dirty_i    (dirty),
    .lru_i      (lru),
    .fill_v_o   (fill_v),
    .fill_set_o (fill_set),
    .fill_way_o (fill_way),
    .dma_pkt_v_o, .dma_pkt_write_o, .dma_pkt_addr_o, .dma_pkt_yumi_i,
    .dma_data_i, .dma_data_v_i, .dma_data_ready_o,
    .dma_data_o, .dma_data_v_o, .dma_data_yumi_i
  );

endmodule

//--- tb/cache_asserts.sv
// Pipeline protocol checks for the data cache
// held responses stay stable, a refill holds the response back and ends in one

`timescale 1ns/1ps

module cache_asserts (
  input logic             clk_i,
  input logic             reset_i,
  input logic             resp_v_i,
  input logic             resp_yumi_i,
  input cache_pkg::word_t resp_data_i,
  input logic             miss_busy_i,
  input logic             miss_done_i
);

  int fail_count = 0;

  // a stalled response keeps its valid and its data
  resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i && !resp_yumi_i |=> resp_v_i && $stable(resp_data_i))
    else begin
      fail_count++;
      $error("response valid dropped or data changed while stalled");
    end

  // the missing item waits in TV until the refill is done
  no_resp_in_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_busy_i |-> !resp_v_i)
    else begin
      fail_count++;
      $error("response offered while the miss unit was busy");
    end

  // the refilled item is offered on the cycle after done
  done_then_resp: assert property (@(posedge clk_i) disable iff (reset_i)
    miss_done_i |=> resp_v_i)
    else begin
      fail_count++;
      $error("no response offered after the refill was done");
    end

endmodule

//--- tb/cache_tb.sv
// Testbench for the data cache
// DMA memory model, shadow memory, LFSR stalls and delays, response checks

`timescale 1ns/1ps

module cache_tb;

  logic             clk_i;
  logic             reset_i;
  logic             v_i;
  logic             store_i;
  cache_pkg::addr_t addr_i;
  cache_pkg::word_t data_i;
  cache_pkg::mask_t mask_i;
  logic             yumi_o;
  cache_pkg::word_t data_o;
  logic             v_o;
  logic             yumi_i;
  logic             dma_pkt_v_o;
  logic             dma_pkt_write_o;
  cache_pkg::addr_t dma_pkt_addr_o;
  logic             dma_pkt_yumi_i;
  cache_pkg::word_t dma_data_i;
  logic             dma_data_v_i;
  logic             dma_data_ready_o;
  cache_pkg::word_t dma_data_o;
  logic             dma_data_v_o;
  logic             dma_data_yumi_i;

  logic [15:0]      lfsr_r = 16'd7066;
  cache_pkg::word_t backing [int];
  cache_pkg::word_t shadow [int];
  cache_pkg::word_t exp_q [$];
  cache_pkg::word_t exp_head;
  cache_pkg::word_t wb_words [4];
  cache_pkg::addr_t last_pkt_addr;
  logic             last_pkt_write;
  int               rd_pkts;
  int               wr_pkts;
  int               dma_mode;
  logic             stall_en;
  int               err_count;
  int               check_count;

  cache cache_i (.*);

  bind cache_pipe cache_asserts asserts_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .resp_v_i    (v_o),
    .resp_yumi_i (yumi_i),
    .resp_data_i (data_o),
    .miss_busy_i (miss.busy),
    .miss_done_i (miss.done)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ 16'hB400) : (lfsr_r >> 1);
      r = {r[30:0], lfsr_r[0]};
    end
    return r;
  endfunction

  function automatic cache_pkg::word_t backing_word(input cache_pkg::addr_t a);
    if (backing.exists(int'(a))) begin
      return backing[int'(a)];
    end
    return 32'(a ^ 16'hA5A5);
  endfunction

  function automatic cache_pkg::word_t shadow_word(input cache_pkg::addr_t a);
    if (shadow.exists(int'(a))) begin
      return shadow[int'(a)];
    end
    return 32'(a ^ 16'hA5A5);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got == exp) else begin
      err_count++;
      $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // caller sits on a falling edge; returns on a falling edge with v_i low
  task automatic issue(input logic st, input cache_pkg::addr_t a,
                       input cache_pkg::word_t d, input cache_pkg::mask_t m);
    int t;
    cache_pkg::word_t w;
    cache_pkg::word_t bm;
    t = 0;
    v_i     = 1'b1;
    store_i = st;
    addr_i  = a;
    data_i  = d;
    mask_i  = m;
    #1;
    while (!yumi_o) begin
      @(negedge clk_i);
      #1;
      t++;
      if (t > 2000) abort_on_timeout("request acceptance");
    end
    if (st) begin
      // each mask bit selects one byte lane of the new data
      bm = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
      w  = (shadow_word(a) & ~bm) | (d & bm);
      shadow[int'(a)] = w;
      exp_q.push_back('0);
    end else begin
      exp_q.push_back(shadow_word(a));
    end
    @(negedge clk_i);
    v_i = 1'b0;
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (exp_q.size() != 0 || dma_mode != 0 || dma_pkt_v_o || v_o) begin
      @(negedge clk_i);
      t++;
      if (t > 4000) abort_on_timeout("the cache to drain");
    end
    @(negedge clk_i);
  endtask

  task automatic report_test(input int n, input string name, input int errs_before);
    $display("test %0d %s: %0d errors", n, name, err_count - errs_before);
  endtask

  // response sink pops the expected value as it takes a response
  initial begin : response_sink
    yumi_i   = 1'b0;
    exp_head = '0;
    forever begin
      @(negedge clk_i);
      yumi_i = 1'b0;
      if (!reset_i && v_o && (!stall_en || rand_bits(1))) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("response at %0t with no request outstanding", $time);
        end else begin
          exp_head = exp_q.pop_front();
          yumi_i   = 1'b1;
        end
      end
    end
  end

  // DMA model, one packet at a time with random delays
  initial begin : dma_model
    int delay;
    int idx;
    cache_pkg::addr_t line;
    dma_pkt_yumi_i  = 1'b0;
    dma_data_v_i    = 1'b0;
    dma_data_i      = '0;
    dma_data_yumi_i = 1'b0;
    dma_mode = 0;
    rd_pkts  = 0;
    wr_pkts  = 0;
    delay    = 0;
    idx      = 0;
    forever begin
      @(negedge clk_i);
      dma_pkt_yumi_i  = 1'b0;
      dma_data_v_i    = 1'b0;
      dma_data_yumi_i = 1'b0;
      if (delay > 0) begin
        delay--;
      end else if (dma_mode == 0 && dma_pkt_v_o && !reset_i) begin
        dma_pkt_yumi_i = 1'b1;
        line           = dma_pkt_addr_o;
        last_pkt_addr  = dma_pkt_addr_o;
        last_pkt_write = dma_pkt_write_o;
        idx            = 0;
        if (dma_pkt_write_o) begin
          wr_pkts++;
          dma_mode = 1;
        end else begin
          rd_pkts++;
          dma_mode = 2;
        end
        delay = rand_bits(2);
      end else if (dma_mode == 1 && dma_data_v_o) begin
        dma_data_yumi_i = 1'b1;
        backing[int'(line) + 4 * idx] = dma_data_o;
        wb_words[idx] = dma_data_o;
        idx++;
        if (idx == 4) dma_mode = 0;
        delay = rand_bits(2);
      end else if (dma_mode == 2 && dma_data_ready_o) begin
        dma_data_v_i = 1'b1;
        dma_data_i   = backing_word(line + 16'(4 * idx));
        idx++;
        if (idx == 4) dma_mode = 0;
        delay = rand_bits(2);
      end
    end
  end

  resp_data: assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && yumi_i |-> data_o == exp_head)
    else begin
      err_count++;
      $display("CHECK FAILED time %0t data_o got %h expected %h",
               $time, $sampled(data_o), $sampled(exp_head));
    end

  pkt_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o && !dma_pkt_yumi_i |=> dma_pkt_v_o && $stable(dma_pkt_addr_o))
    else begin
      err_count++;
      $display("DMA packet dropped or changed before it was taken at %0t", $time);
    end

  // a new packet waits until the last transfer has moved all its words
  one_pkt: assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o && !dma_pkt_yumi_i |-> dma_mode == 0)
    else begin
      err_count++;
      $display("DMA packet offered during a data transfer at %0t", $time);
    end

  initial begin : main
    int e;
    int rd0;
    int wr0;
    err_count   = 0;
    check_count = 0;
    stall_en    = 1'b0;
    reset_i     = 1'b1;
    v_i         = 1'b0;
    store_i     = 1'b0;
    addr_i      = '0;
    data_i      = '0;
    mask_i      = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    #1;

    e = err_count;
    check_value("v_o", v_o, 0);
    check_value("yumi_o", yumi_o, 0);
    check_value("dma_pkt_v_o", dma_pkt_v_o, 0);
    check_value("dma_data_v_o", dma_data_v_o, 0);
    @(negedge clk_i);
    issue(1'b0, 16'h0104, '0, '0);
    wait_idle();
    check_value("read packets", rd_pkts, 1);
    check_value("dma_pkt_addr_o", last_pkt_addr, 16'h0100);
    check_value("dma_pkt_write_o", last_pkt_write, 0);
    report_test(1, "reset and first miss", e);

    e   = err_count;
    rd0 = rd_pkts;
    issue(1'b1, 16'h0104, 32'h1122_3344, 4'b0101);
    issue(1'b0, 16'h0104, '0, '0);
    issue(1'b0, 16'h0108, '0, '0);
    wait_idle();
    check_value("read packets", rd_pkts, rd0);
    report_test(2, "masked store and hits", e);

    e   = err_count;
    wr0 = wr_pkts;
    issue(1'b1, 16'h0120, 32'hCAFE_F00D, 4'hF);
    wait_idle();
    issue(1'b0, 16'h0220, '0, '0);
    issue(1'b0, 16'h0320, '0, '0);
    wait_idle();
    check_value("write packets", wr_pkts, wr0 + 1);
    for (int i = 0; i < 4; i++) begin
      check_value("dma_data_o", wb_words[i], shadow_word(16'h0120 + 16'(4 * i)));
    end
    issue(1'b0, 16'h0120, '0, '0);
    wait_idle();
    report_test(3, "dirty eviction", e);

    e = err_count;
    issue(1'b0, 16'h1050, '0, '0);
    wait_idle();
    issue(1'b0, 16'h2050, '0, '0);
    wait_idle();
    issue(1'b0, 16'h1050, '0, '0);
    wait_idle();
    issue(1'b0, 16'h3050, '0, '0);
    wait_idle();
    rd0 = rd_pkts;
    issue(1'b0, 16'h1050, '0, '0);
    wait_idle();
    check_value("read packets", rd_pkts, rd0);
    issue(1'b0, 16'h2050, '0, '0);
    wait_idle();
    check_value("read packets", rd_pkts, rd0 + 1);
    report_test(4, "lru replacement", e);

    e = err_count;
    stall_en = 1'b1;
    for (int n = 0; n < 60; n++) begin
      logic             st;
      cache_pkg::addr_t a;
      cache_pkg::word_t d;
      cache_pkg::mask_t m;
      st = rand_bits(1);
      a  = {6'(rand_bits(2)), 2'b01, 3'b100, 1'(rand_bits(1)), 2'(rand_bits(2)), 2'b00};
      d  = rand_bits(32);
      m  = rand_bits(4);
      issue(st, a, d, m);
    end
    wait_idle();
    stall_en = 1'b0;
    report_test(5, "random traffic with stalls", e);

    e = err_count + cache_i.pipe_i.asserts_i.fail_count;
    $display("tests 5, checks %0d, errors %0d", check_count, e);
    if (e == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/sram_if.sv
rtl/miss_if.sv
rtl/cache_sram.sv
rtl/cache_stat_regs.sv
rtl/cache_miss.sv
rtl/cache_pipe.sv
rtl/cache.sv
tb/cache_asserts.sv
tb/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/sram_if.sv
      - rtl/miss_if.sv
      - rtl/cache_sram.sv
      - rtl/cache_stat_regs.sv
      - rtl/cache_miss.sv
      - rtl/cache_pipe.sv
      - rtl/cache.sv
  - target: test
    files:
      - tb/cache_asserts.sv
      - tb/cache_tb.sv
